// File: rf_controller.f
+incdir+logic
+incdir+tests
logic/p_rfctrl.sv
logic/rf_memory.sv
logic/rf_read_check.sv
logic/rf_write_arbiter.sv
logic/rf_controller.sv
tests/tb_rf_controller.sv

// File: Makefile
SRCS := $(wildcard logic/*.sv logic/*.svh tests/*.sv tests/*.svh)

run: obj_dir/Vtb_rf_controller
	./obj_dir/Vtb_rf_controller

obj_dir/Vtb_rf_controller: rf_controller.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f rf_controller.f --top-module tb_rf_controller

clean:
	rm -rf obj_dir

.PHONY: run clean

// File: tests/tb_rf_table.svh
`ifndef TB_RF_TABLE_SVH
`define TB_RF_TABLE_SVH

localparam int OP_IDLE = 0;                     // nothing driven but the read addresses
localparam int OP_WB   = 1;                     // write-back strobe from the core
localparam int OP_INJ  = 2;                     // fault injection strobe
localparam int OP_READ = 3;                     // reads only with outputs checked

localparam logic [7:0] CTRL_DEST   = 8'(1 << ICTRL_REG_DEST);
localparam logic [7:0] CTRL_NODEST = ~CTRL_DEST;    // busy control word without a destination

typedef struct {
   int               op;
   logic [4:0]       wadd;
   logic [7:0]       ctrl;
   logic [`RF_W-1:0] wdata;                     // filled from $random at build time
   logic [4:0]       inj_add;
   logic [`RF_CW-1:0] inj_mask;
   logic [4:0]       ra1;
   logic [4:0]       ra2;
   logic             chk;                       // compare the read ports in this row
} row_t;

row_t rows[$];
integer seed = 82;

task automatic push_row(input int op, input int wadd, input logic [7:0] ctrl,
                        input int inj_add, input logic [`RF_CW-1:0] inj_mask,
                        input int ra1, input int ra2, input logic chk);
   row_t r;
   r.op       = op;
   r.wadd     = 5'(wadd);
   r.ctrl     = ctrl;
   r.wdata    = $random(seed);
   r.inj_add  = 5'(inj_add);
   r.inj_mask = inj_mask;
   r.ra1      = 5'(ra1);
   r.ra2      = 5'(ra2);
   r.chk      = chk;
   rows.push_back(r);
endtask

task automatic add_wb(input int add, input logic [7:0] ctrl, input int ra1, input int ra2);
   push_row(OP_WB, add, ctrl, 0, '0, ra1, ra2, 1'b1);
endtask

task automatic add_inj(input int add, input logic [`RF_CW-1:0] mask);
   push_row(OP_INJ, 0, 8'h00, add, mask, 1, 2, 1'b1);    // reads stay on clean registers
endtask

task automatic add_read(input int ra1, input int ra2);
   push_row(OP_READ, 0, 8'h00, 0, '0, ra1, ra2, 1'b1);
endtask

task automatic add_idle();
   push_row(OP_IDLE, 0, 8'h00, 0, '0, 0, 0, 1'b0);       // x0 reads never flag
endtask

task automatic build_table();
   // fill every register while each row reads back the previous one
   for (int r = 0; r < `RF_N; r++)
      add_wb(r, CTRL_DEST, (r == 0) ? 0 : r - 1, 0);
   add_read(`RF_N - 1, 0);
   for (int r = 0; r < `RF_N; r++)
      add_read(r, `RF_N - 1 - r);                        // both ports over the whole array

   add_wb(0, CTRL_DEST, 0, 0);                           // x0 is hardwired
   add_read(0, 0);
   add_wb(5, CTRL_NODEST, 5, 5);                         // no destination means no write
   add_read(5, 5);

   add_inj(7, 39'h8);                                    // one data bit repaired via port 1
   add_read(7, 9);
   add_idle();
   add_idle();
   add_read(7, 9);
   add_inj(8, 39'h400);                                  // same again through port 2
   add_read(9, 8);
   add_idle();
   add_idle();
   add_read(8, 9);

   add_inj(10, 39'h6);                                   // two check bits so data stays intact
   add_read(1, 10);
   add_idle();
   add_idle();
   add_read(10, 10);

   add_inj(12, 39'h20);
   add_read(12, 1);
   add_wb(12, CTRL_DEST, 1, 2);                          // supersedes the queued repair
   add_idle();
   add_idle();
   add_read(12, 12);

   add_inj(14, 39'h100);
   add_inj(15, 39'h1000);
   add_read(14, 15);                                     // only port 1 fits the buffer
   add_idle();
   add_idle();
   add_read(14, 15);
   add_idle();
   add_read(15, 14);
endtask

`endif

// File: tests/tb_rf_controller.sv
`timescale 1ns/1ps
`include "rf_macros.svh"

module tb_rf_controller;
   import p_rfctrl::*;

   `include "tb_rf_table.svh"

   logic s_clk = 1'b0;
   logic rst;
   logic [`RF_W-1:0] mawb_val;
   logic [4:0] mawb_add;
   logic [7:0] mawb_ictrl;
   logic [4:0] ra1;
   logic [4:0] ra2;
   logic inj;
   logic [4:0] inj_add;
   logic [`RF_CW-1:0] inj_mask;
   logic [`RF_W-1:0] p1_val;
   logic [`RF_W-1:0] p2_val;
   logic [1:0] ce;
   logic [1:0] uce;

   logic [`RF_W-1:0] m_val [`RF_N];             // last value written per register
   int m_cnt [`RF_N];                           // bits flipped since that write
   logic rep_v;                                 // repair the DUT should be holding
   logic [4:0] rep_add;
   logic [`RF_W-1:0] rep_val;
   int cyc_cnt = 0;

   always #20 s_clk = ~s_clk;                   // 40 ns period

   rf_controller UUT (
      .s_clk_i        (s_clk),
      .rst_i          (rst),
      .s_mawb_val_i   (mawb_val),
      .s_mawb_add_i   (mawb_add),
      .s_mawb_ictrl_i (mawb_ictrl),
      .s_r_p1_add_i   (ra1),
      .s_r_p2_add_i   (ra2),
      .s_inj_i        (inj),
      .s_inj_add_i    (inj_add),
      .s_inj_mask_i   (inj_mask),
      .s_p1_val_o     (p1_val),
      .s_p2_val_o     (p2_val),
      .s_ce_o         (ce),
      .s_uce_o        (uce)
   );

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_value(input string name, input logic [`RF_W-1:0] exp,
                               input logic [`RF_W-1:0] act);
      stop_on_error($sformatf("FAIL at %0d ns: %s expected %h, got %h", $time, name, exp, act));
   endtask

   // odd flip count means one bad bit and even nonzero means two (table never goes past two)
   function automatic logic is_correctable(input int cnt);
      return (cnt % 2) == 1;
   endfunction

   function automatic logic is_uncorrectable(input int cnt);
      return (cnt != 0) && ((cnt % 2) == 0);
   endfunction

   task automatic drive_row(input row_t r);
      mawb_val   = r.wdata;
      mawb_add   = (r.op == OP_WB) ? r.wadd : 5'd0;
      mawb_ictrl = (r.op == OP_WB) ? r.ctrl : 8'h00;
      inj        = (r.op == OP_INJ);
      inj_add    = r.inj_add;
      inj_mask   = r.inj_mask;
      ra1        = r.ra1;
      ra2        = r.ra2;
   endtask

   task automatic check_outputs(input row_t r);
      logic [`RF_W-1:0] e1;
      logic [`RF_W-1:0] e2;
      logic [1:0] ece;
      logic [1:0] euce;
      e1   = m_val[r.ra1];                      // single errors come back corrected
      e2   = m_val[r.ra2];
      ece  = {is_correctable(m_cnt[r.ra2]), is_correctable(m_cnt[r.ra1])};
      euce = {is_uncorrectable(m_cnt[r.ra2]), is_uncorrectable(m_cnt[r.ra1])};
      assert (p1_val === e1) else report_value("s_p1_val_o", e1, p1_val);
      assert (p2_val === e2) else report_value("s_p2_val_o", e2, p2_val);
      assert (ce === ece) else report_value("s_ce_o", 32'(ece), 32'(ce));
      assert (uce === euce) else report_value("s_uce_o", 32'(euce), 32'(uce));
   endtask

   // state after the coming edge
   task automatic update_model(input row_t r);
      logic wb_req;
      logic ce1;
      logic ce2;
      logic wr_en;
      logic [4:0] wr_add;
      logic [4:0] cap_add;
      wb_req = (r.op == OP_WB) && r.ctrl[ICTRL_REG_DEST] && (r.wadd != 5'd0);
      ce1    = is_correctable(m_cnt[r.ra1]);
      ce2    = is_correctable(m_cnt[r.ra2]);
      wr_en  = wb_req || rep_v;                 // write-back first and repair in idle slots
      wr_add = wb_req ? r.wadd : rep_add;
      cap_add = ce1 ? r.ra1 : r.ra2;
      if ((r.op == OP_INJ) && (r.inj_add != 5'd0) && !(wr_en && (wr_add == r.inj_add)))
         m_cnt[r.inj_add] += $countones(r.inj_mask);
      if (rep_v) begin
         if (!wb_req) begin
            m_val[rep_add] = rep_val;           // repair lands
            m_cnt[rep_add] = 0;
            rep_v = 1'b0;
         end else if (r.wadd == rep_add) begin
            rep_v = 1'b0;                       // newer value drops the repair
         end
      end else if ((ce1 || ce2) && !(wb_req && (r.wadd == cap_add))) begin
         rep_v   = 1'b1;
         rep_add = cap_add;
         rep_val = m_val[cap_add];
      end
      if (wb_req) begin
         m_val[r.wadd] = r.wdata;
         m_cnt[r.wadd] = 0;
      end
   endtask

   always @(posedge s_clk) begin
      cyc_cnt = cyc_cnt + 1;
      if (cyc_cnt >= 2 * rows.size() + 16)
         stop_on_error($sformatf("timeout: no result after %0d cycles", cyc_cnt));
   end

   initial begin
      rst        = 1'b1;
      mawb_val   = '0;
      mawb_add   = '0;
      mawb_ictrl = '0;
      ra1        = '0;
      ra2        = '0;
      inj        = 1'b0;
      inj_add    = '0;
      inj_mask   = '0;
      rep_v      = 1'b0;
      rep_add    = '0;
      rep_val    = '0;
      for (int i = 0; i < `RF_N; i++) begin
         m_val[i] = '0;                         // x0 stays zero and the rest are written first
         m_cnt[i] = 0;
      end
      build_table();
      repeat (16) @(posedge s_clk);
      #2;
      rst = 1'b0;
      for (int i = 0; i < rows.size(); i++) begin
         drive_row(rows[i]);
         #36;                                   // just before the next rising edge
         if (rows[i].chk)
            check_outputs(rows[i]);
         update_model(rows[i]);
         @(posedge s_clk);
         #2;
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// File: logic/rf_controller.sv
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_controller (
   input  logic                 s_clk_i,          // clock
   input  logic                 rst_i,            // sync reset, active high
   input  logic [`RF_W-1:0]     s_mawb_val_i,     // result from wb stage
   input  p_rfctrl::rf_add      s_mawb_add_i,     // destination from wb stage
   input  p_rfctrl::ictrl       s_mawb_ictrl_i,   // control word from wb stage
   input  p_rfctrl::rf_add      s_r_p1_add_i,     // read port 1 address
   input  p_rfctrl::rf_add      s_r_p2_add_i,     // read port 2 address
   input  logic                 s_inj_i,          // fault injection strobe
   input  p_rfctrl::rf_add      s_inj_add_i,      // injection target
   input  logic [`RF_CW-1:0]    s_inj_mask_i,     // stored bits to flip
   output logic [`RF_W-1:0]     s_p1_val_o,       // read value, port 1
   output logic [`RF_W-1:0]     s_p2_val_o,       // read value, port 2
   output logic [1:0]           s_ce_o,           // correctable error per port
   output logic [1:0]           s_uce_o           // uncorrectable error per port
);
   import p_rfctrl::*;

   logic s_rf_we;                                 // arbitrated write strobe
   rf_add s_rf_wadd;                              // arbitrated write address
   logic [`RF_CW-1:0] s_rf_wval;                  // encoded write word
   logic [`RF_CW-1:0] s_rp_word [2];              // raw words per port
   logic [`RF_W-1:0] s_rp_val [2];                // checked data per port
   logic [1:0] s_ce;                              // also feeds the repair buffer
   logic [1:0] s_uce;

   assign s_p1_val_o = s_rp_val[0];
   assign s_p2_val_o = s_rp_val[1];
   assign s_ce_o     = s_ce;
   assign s_uce_o    = s_uce;

   rf_memory m_mem (
      .s_clk_i      (s_clk_i),
      .s_we_i       (s_rf_we),
      .s_wadd_i     (s_rf_wadd),
      .s_wval_i     (s_rf_wval),
      .s_inj_i      (s_inj_i),
      .s_inj_add_i  (s_inj_add_i),
      .s_inj_mask_i (s_inj_mask_i),
      .s_radd1_i    (s_r_p1_add_i),
      .s_radd2_i    (s_r_p2_add_i),
      .s_rval1_o    (s_rp_word[0]),
      .s_rval2_o    (s_rp_word[1])
   );

   rf_read_check m_chk_p1 (
      .s_word_i (s_rp_word[0]),
      .s_val_o  (s_rp_val[0]),
      .s_ce_o   (s_ce[0]),
      .s_uce_o  (s_uce[0])
   );

   rf_read_check m_chk_p2 (
      .s_word_i (s_rp_word[1]),
      .s_val_o  (s_rp_val[1]),
      .s_ce_o   (s_ce[1]),
      .s_uce_o  (s_uce[1])
   );

   // write-back and repair share the single array write port
   rf_write_arbiter m_arb (
      .s_clk_i      (s_clk_i),
      .rst_i        (rst_i),
      .s_wb_val_i   (s_mawb_val_i),
      .s_wb_add_i   (s_mawb_add_i),
      .s_wb_ictrl_i (s_mawb_ictrl_i),
      .s_ce_i       (s_ce),
      .s_radd1_i    (s_r_p1_add_i),
      .s_radd2_i    (s_r_p2_add_i),
      .s_cval1_i    (s_rp_val[0]),
      .s_cval2_i    (s_rp_val[1]),
      .s_we_o       (s_rf_we),
      .s_wadd_o     (s_rf_wadd),
      .s_wval_o     (s_rf_wval)
   );

endmodule

// File: logic/rf_write_arbiter.sv
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_write_arbiter (
   input  logic                 s_clk_i,        // clock
   input  logic                 rst_i,          // sync reset, active high
   input  logic [`RF_W-1:0]     s_wb_val_i,     // write-back result
   input  p_rfctrl::rf_add      s_wb_add_i,     // write-back destination
   input  p_rfctrl::ictrl       s_wb_ictrl_i,   // write-back control word
   input  logic [1:0]           s_ce_i,         // correctable flags, bit 0 is port 1
   input  p_rfctrl::rf_add      s_radd1_i,      // address read on port 1
   input  p_rfctrl::rf_add      s_radd2_i,      // address read on port 2
   input  logic [`RF_W-1:0]     s_cval1_i,      // corrected data, port 1
   input  logic [`RF_W-1:0]     s_cval2_i,      // corrected data, port 2
   output logic                 s_we_o,         // array write strobe
   output p_rfctrl::rf_add      s_wadd_o,       // array write address
   output logic [`RF_CW-1:0]    s_wval_o        // encoded array write word
);
   import p_rfctrl::*;

   logic s_wb_req;                              // write-back wants the port
   logic r_rep_v;                               // repair pending
   rf_add r_rep_add;                            // register to repair
   logic [`RF_W-1:0] r_rep_val;                 // corrected value to store
   rf_add s_cap_add;                            // candidate from the read ports
   logic [`RF_W-1:0] s_cap_val;
   logic s_cap;                                 // load the buffer this edge
   logic s_rep_done;                            // repair written or cancelled

   // x0 writes are dropped here so they never reach the port
   assign s_wb_req  = s_wb_ictrl_i[ICTRL_REG_DEST] && (s_wb_add_i != '0);

   // port 1 first when both flag
   assign s_cap_add = s_ce_i[0] ? s_radd1_i : s_radd2_i;
   assign s_cap_val = s_ce_i[0] ? s_cval1_i : s_cval2_i;

   // a write-back to the same register this cycle already holds newer data
   assign s_cap     = !r_rep_v && (|s_ce_i)
                      && !(s_wb_req && (s_wb_add_i == s_cap_add));

   // leaves when it gets the port, or when write-back overwrites its target
   assign s_rep_done = !s_wb_req || (s_wb_add_i == r_rep_add);

   always_ff @(posedge s_clk_i) begin
      if (rst_i) begin
         r_rep_v <= 1'b0;
      end else if (r_rep_v) begin
         if (s_rep_done)
            r_rep_v <= 1'b0;
      end else if (s_cap) begin
         r_rep_v <= 1'b1;                       // full buffer ignores new flags
      end
   end

   always_ff @(posedge s_clk_i) begin
      if (s_cap) begin
         r_rep_add <= s_cap_add;
         r_rep_val <= s_cap_val;
      end
   end

   // write-back always wins, repair fills idle slots
   assign s_we_o   = s_wb_req || r_rep_v;
   assign s_wadd_o = s_wb_req ? s_wb_add_i : r_rep_add;
   assign s_wval_o = rf_encode(s_wb_req ? s_wb_val_i : r_rep_val);

endmodule

// File: logic/rf_read_check.sv
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_read_check (
   input  logic [`RF_CW-1:0]  s_word_i,   // raw word from the array
   output logic [`RF_W-1:0]   s_val_o,    // corrected or raw data
   output logic               s_ce_o,     // single bit error, corrected
   output logic               s_uce_o     // double bit error, data not trusted
);
   import p_rfctrl::*;

   logic [`RF_ECC-1:0] s_syn;             // parity in msb, bit position below
   logic s_odd;                           // overall parity mismatch
   logic s_pos_nz;                        // hamming part points somewhere

   assign s_syn    = rf_syndrome(s_word_i);
   assign s_odd    = s_syn[`RF_ECC-1];
   assign s_pos_nz = |s_syn[`RF_ECC-2:0];

   // clean word passes through untouched, double error leaves data raw
   assign s_val_o  = rf_correct(s_word_i, s_syn);

   // odd parity means one flipped bit, even parity with a position means two
   assign s_ce_o   = s_odd;
   assign s_uce_o  = !s_odd && s_pos_nz;

endmodule

// File: logic/rf_memory.sv
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_memory (
   input  logic                 s_clk_i,        // array clock
   input  logic                 s_we_i,         // write strobe from arbiter
   input  p_rfctrl::rf_add      s_wadd_i,       // write address
   input  logic [`RF_CW-1:0]    s_wval_i,       // encoded write word
   input  logic                 s_inj_i,        // fault injection strobe
   input  p_rfctrl::rf_add      s_inj_add_i,    // entry to corrupt
   input  logic [`RF_CW-1:0]    s_inj_mask_i,   // bits to flip
   input  p_rfctrl::rf_add      s_radd1_i,      // read port 1 address
   input  p_rfctrl::rf_add      s_radd2_i,      // read port 2 address
   output logic [`RF_CW-1:0]    s_rval1_o,      // raw stored word, port 1
   output logic [`RF_CW-1:0]    s_rval2_o       // raw stored word, port 2
);
   import p_rfctrl::*;

   logic [`RF_CW-1:0] r_mem [`RF_N];            // encoded registers, entry 0 unused
   logic s_wr_hit;                              // write lands on this edge
   logic s_inj_hit;                             // injection lands on this edge

   assign s_wr_hit  = s_we_i && (s_wadd_i != '0);
   // a write to the same entry replaces the word, so the flip is dropped
   assign s_inj_hit = s_inj_i && (s_inj_add_i != '0)
                      && !(s_wr_hit && (s_wadd_i == s_inj_add_i));

   always_ff @(posedge s_clk_i) begin
      if (s_wr_hit)
         r_mem[s_wadd_i] <= s_wval_i;
      if (s_inj_hit)
         r_mem[s_inj_add_i] <= r_mem[s_inj_add_i] ^ s_inj_mask_i;   // xor in the upset
   end

   // x0 is hardwired, reads give a clean encoded zero
   assign s_rval1_o = (s_radd1_i == '0) ? rf_encode('0) : r_mem[s_radd1_i];
   assign s_rval2_o = (s_radd2_i == '0) ? rf_encode('0) : r_mem[s_radd2_i];

endmodule

// File: logic/p_rfctrl.sv
`include "rf_macros.svh"

package p_rfctrl;

   typedef logic [$clog2(`RF_N)-1:0] rf_add;        // register address
   typedef logic [7:0] ictrl;                       // instruction control from wb stage

   localparam int unsigned ICTRL_REG_DEST = 0;      // instruction writes a destination register

   // stored word layout: bit 0 holds overall parity, bits 1..38 are the hamming
   // codeword, with check bits at the power-of-two positions and data elsewhere

   function automatic logic rf_is_chk(input int unsigned pos);
      return (pos & (pos - 1)) == 0;                // power of two, so a check position
   endfunction

   function automatic logic [`RF_CW-1:0] rf_encode(input logic [`RF_W-1:0] data);
      logic [`RF_CW-1:0] word;
      logic p;
      int unsigned j;
      word = '0;
      j    = 0;
      for (int unsigned i = 1; i < `RF_CW; i++) begin
         if (!rf_is_chk(i)) begin
            word[i] = data[j];                      // data fills the non-check slots in order
            j++;
         end
      end
      for (int unsigned k = 0; k < `RF_ECC-1; k++) begin
         p = 1'b0;
         for (int unsigned i = 1; i < `RF_CW; i++) begin
            if (((i >> k) & 1) != 0)
               p ^= word[i];                        // check slot itself is still zero here
         end
         word[1 << k] = p;
      end
      word[0] = ^word[`RF_CW-1:1];                  // overall parity makes the word even
      return word;
   endfunction

   // syn[6] is the overall parity, syn[5:0] the position of a single flipped bit
   function automatic logic [`RF_ECC-1:0] rf_syndrome(input logic [`RF_CW-1:0] word);
      logic [`RF_ECC-1:0] syn;
      syn = '0;
      for (int unsigned k = 0; k < `RF_ECC-1; k++) begin
         for (int unsigned i = 1; i < `RF_CW; i++) begin
            if (((i >> k) & 1) != 0)
               syn[k] ^= word[i];
         end
      end
      syn[`RF_ECC-1] = ^word;                       // odd means an odd number of bad bits
      return syn;
   endfunction

   function automatic logic [`RF_W-1:0] rf_correct(input logic [`RF_CW-1:0] word,
                                                   input logic [`RF_ECC-1:0] syn);
      logic [`RF_CW-1:0] fixed;
      logic [`RF_W-1:0] data;
      int unsigned j;
      fixed = word;
      data  = '0;
      j     = 0;
      if (syn[`RF_ECC-1]) begin                     // only a single error gets flipped
         for (int unsigned i = 0; i < `RF_CW; i++) begin
            if (i == syn[`RF_ECC-2:0])
               fixed[i] = ~fixed[i];                // position 0 is the parity bit itself
         end
      end
      for (int unsigned i = 1; i < `RF_CW; i++) begin
         if (!rf_is_chk(i)) begin
            data[j] = fixed[i];                     // gather data back in encode order
            j++;
         end
      end
      return data;
   endfunction

endpackage

// File: logic/rf_macros.svh
`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// register file geometry
`define RF_W    32                  // data bits per register
`define RF_N    32                  // number of general registers

// extended hamming protection of one register
`define RF_ECC  7                   // 6 hamming check bits + overall parity
`define RF_CW   39                  // stored word, data plus check bits

`endif
